// File: include/fp_settings.svh
`ifndef FP_SETTINGS_SVH
`define FP_SETTINGS_SVH

// --------------------------------------------------
// Single-precision field layout
// --------------------------------------------------

// Exponent field width
`define FP_EXP_WIDTH 8

// Stored fraction width, hidden bit not counted
`define FP_SIG_WIDTH 23

// Exponent bias
`define FP_EXP_BIAS 127

// Default depth of the retiming register chain
`define FP_MULT_STAGES 5

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Build fp_mult_tb with Verilator, run it, and judge the run from its log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module fp_mult_tb -o fp_mult_sim \
    && ./obj_dir/fp_mult_sim | tee sim.log \
    || { echo "Build or simulation run failed"; exit 1; }
grep -q "TESTS PASSED" sim.log && exit 0 || exit 1

// File: sources.f
+incdir+include
src/fp_pkg.sv
src/fp_mul_classify.sv
src/fp_mul_round.sv
src/fp_mult_core.sv
src/fp_mult_pipe.sv
src/fp_mult_top.sv
tests/fp_mult_tb.sv

// File: src/fp_mul_classify.sv
`include "fp_settings.svh"

module fp_mul_classify (
    input  fp_pkg::fp_word_t a,
    input  fp_pkg::fp_word_t b,
    output logic             a_sign,
    output logic             b_sign,
    output fp_pkg::fp_exp_t  a_exp,
    output fp_pkg::fp_exp_t  b_exp,
    output fp_pkg::fp_sig_t  a_sig,
    output fp_pkg::fp_sig_t  b_sig,
    output logic             a_zero,
    output logic             b_zero,
    output logic             a_inf,
    output logic             b_inf,
    output logic             a_nan,
    output logic             b_nan
);

    localparam int EW = `FP_EXP_WIDTH;
    localparam int SW = `FP_SIG_WIDTH;

    // Raw fields
    logic [EW-1:0] a_field;
    logic [EW-1:0] b_field;
    logic [SW-1:0] a_frac;
    logic [SW-1:0] b_frac;
    // All-ones exponent, either infinity or NaN
    logic          a_top;
    logic          b_top;

    // --------------------------------------------------
    // Unpack
    // --------------------------------------------------
    assign a_sign  = a[EW+SW];
    assign b_sign  = b[EW+SW];
    assign a_field = a[EW+SW-1:SW];
    assign b_field = b[EW+SW-1:SW];
    assign a_frac  = a[SW-1:0];
    assign b_frac  = b[SW-1:0];

    // Zero-extend into the wider signed exponent
    assign a_exp = fp_pkg::fp_exp_t'({2'b00, a_field});
    assign b_exp = fp_pkg::fp_exp_t'({2'b00, b_field});

    // --------------------------------------------------
    // Classes
    // --------------------------------------------------
    // Zero exponent field covers denormals too, so they flush here
    assign a_zero = (a_field == '0);
    assign b_zero = (b_field == '0);
    assign a_top  = (a_field == '1);
    assign b_top  = (b_field == '1);

    // Fraction decides infinity against NaN
    assign a_inf = a_top && (a_frac == '0);
    assign b_inf = b_top && (b_frac == '0);
    assign a_nan = a_top && (a_frac != '0);
    assign b_nan = b_top && (b_frac != '0);

    // Hidden bit only for non-zero operands
    // A flushed operand carries an all-zero significand
    assign a_sig = a_zero ? '0 : {1'b1, a_frac};
    assign b_sig = b_zero ? '0 : {1'b1, b_frac};

endmodule

// File: src/fp_mul_round.sv
`include "fp_settings.svh"

module fp_mul_round (
    input  logic             clk,
    input  logic             sign,
    input  fp_pkg::fp_exp_t  exp_sum,
    input  fp_pkg::fp_sig_t  a_sig,
    input  fp_pkg::fp_sig_t  b_sig,
    output fp_pkg::fp_word_t result,
    output logic             overflow,
    output logic             underflow
);

    localparam int EW = `FP_EXP_WIDTH;
    localparam int SW = `FP_SIG_WIDTH;
    localparam int PW = 2 * SW + 2;
    // First exponent value that no longer fits a finite number
    localparam fp_pkg::fp_exp_t EXP_LIMIT = fp_pkg::fp_exp_t'((1 << EW) - 1);

    fp_pkg::fp_prod_t prod;
    // Product with its leading one in the top bit
    fp_pkg::fp_prod_t norm;
    fp_pkg::fp_exp_t  exp_norm;
    fp_pkg::fp_exp_t  exp_final;
    logic             lsb_bit;
    logic             guard_bit;
    logic             sticky_bit;
    logic             round_up;
    // One spare bit on top to catch the rounding carry
    logic [SW+1:0]    sig_rounded;
    logic             round_carry;
    logic [SW-1:0]    frac_out;

    // --------------------------------------------------
    // Multiply and normalize
    // --------------------------------------------------
    assign prod = a_sig * b_sig;

    // Product lies in [1,4), top bit set means [2,4)
    // so the exponent goes up by one instead of shifting the product
    assign norm     = prod[PW-1] ? prod : (prod << 1);
    assign exp_norm = prod[PW-1] ? exp_sum + fp_pkg::fp_exp_t'(1) : exp_sum;

    // --------------------------------------------------
    // Round to nearest, ties to even
    // --------------------------------------------------
    assign lsb_bit    = norm[PW-SW-1];
    assign guard_bit  = norm[PW-SW-2];
    assign sticky_bit = |norm[PW-SW-3:0];

    // Above half, or exactly half with an odd kept value
    assign round_up = guard_bit && (sticky_bit || lsb_bit);

    assign sig_rounded = {1'b0, norm[PW-1 -: SW+1]} + (SW+2)'(round_up);
    assign round_carry = sig_rounded[SW+1];

    // Carry out leaves 10.000..., renormalize by one place
    assign frac_out  = round_carry ? sig_rounded[SW:1] : sig_rounded[SW-1:0];
    assign exp_final = exp_norm + fp_pkg::fp_exp_t'(round_carry);

    // --------------------------------------------------
    // Range and packing
    // --------------------------------------------------
    assign overflow  = (exp_final >= EXP_LIMIT);
    assign underflow = (exp_final <= fp_pkg::fp_exp_t'(0));

    // Only meaningful when neither flag is up
    assign result = {sign, exp_final[EW-1:0], frac_out};

    // Two normal significands must give a normalized product
    assert property (@(posedge clk)
        (a_sig[SW] && b_sig[SW]) |-> norm[PW-1])
        else $error("fp_mul_round: normalized significand lost its leading bit");

endmodule

// File: src/fp_mult_core.sv
`include "fp_settings.svh"

module fp_mult_core (
    input  logic             clk,
    input  fp_pkg::fp_word_t a,
    input  fp_pkg::fp_word_t b,
    output fp_pkg::fp_word_t z
);

    localparam int EW = `FP_EXP_WIDTH;
    localparam int SW = `FP_SIG_WIDTH;
    // Canonical quiet NaN, positive, top fraction bit only
    localparam fp_pkg::fp_word_t NAN_WORD = {1'b0, {EW{1'b1}}, 1'b1, {(SW-1){1'b0}}};

    logic             a_sign;
    logic             b_sign;
    fp_pkg::fp_exp_t  a_exp;
    fp_pkg::fp_exp_t  b_exp;
    fp_pkg::fp_sig_t  a_sig;
    fp_pkg::fp_sig_t  b_sig;
    logic             a_zero;
    logic             b_zero;
    logic             a_inf;
    logic             b_inf;
    logic             a_nan;
    logic             b_nan;
    logic             z_sign;
    fp_pkg::fp_exp_t  exp_sum;
    fp_pkg::fp_word_t finite_z;
    logic             overflow;
    logic             underflow;
    logic             nan_case;
    logic             inf_case;
    logic             zero_case;

    // --------------------------------------------------
    // Operand split and finite product
    // --------------------------------------------------
    fp_mul_classify u_classify (
        .a      (a),
        .b      (b),
        .a_sign (a_sign),
        .b_sign (b_sign),
        .a_exp  (a_exp),
        .b_exp  (b_exp),
        .a_sig  (a_sig),
        .b_sig  (b_sig),
        .a_zero (a_zero),
        .b_zero (b_zero),
        .a_inf  (a_inf),
        .b_inf  (b_inf),
        .a_nan  (a_nan),
        .b_nan  (b_nan)
    );

    assign z_sign  = a_sign ^ b_sign;
    // One bias too many after the add
    assign exp_sum = a_exp + b_exp - fp_pkg::fp_exp_t'(`FP_EXP_BIAS);

    fp_mul_round u_round (
        .clk       (clk),
        .sign      (z_sign),
        .exp_sum   (exp_sum),
        .a_sig     (a_sig),
        .b_sig     (b_sig),
        .result    (finite_z),
        .overflow  (overflow),
        .underflow (underflow)
    );

    // --------------------------------------------------
    // Special-case selection
    // --------------------------------------------------
    // Infinity times zero has no defined value
    assign nan_case  = a_nan || b_nan || (a_inf && b_zero) || (b_inf && a_zero);
    assign inf_case  = a_inf || b_inf || overflow;
    assign zero_case = a_zero || b_zero || underflow;

    // Priority: NaN, then infinity, then zero
    always_comb begin
        if (nan_case) begin
            z = NAN_WORD;
        end else if (inf_case) begin
            z = {z_sign, {EW{1'b1}}, {SW{1'b0}}};
        end else if (zero_case) begin
            z = {z_sign, {(EW+SW){1'b0}}};
        end else begin
            z = finite_z;
        end
    end

    // Any NaN leaving the core is the canonical one
    assert property (@(posedge clk)
        ((z[EW+SW-1:SW] == '1) && (z[SW-1:0] != '0)) |-> (z == NAN_WORD))
        else $error("fp_mult_core: NaN result with non-canonical payload %h", z);

endmodule

// File: src/fp_mult_pipe.sv
`include "fp_settings.svh"

module fp_mult_pipe #(
    parameter int stages = `FP_MULT_STAGES
) (
    input  logic             clk,
    input  logic             rst_n,
    input  fp_pkg::fp_word_t a,
    input  fp_pkg::fp_word_t b,
    input  logic             ab_valid,
    output fp_pkg::fp_word_t z,
    output logic             z_valid
);

    // Combinational product, before any register
    fp_pkg::fp_word_t z_core;

    // Result and valid chain, index 0 is nearest the core
    fp_pkg::fp_word_t pipe_z     [stages];
    logic             pipe_valid [stages];

    // Depth of zero would leave the output unregistered
    if (stages < 1) begin : g_bad_depth
        $error("fp_mult_pipe: stages must be 1 or more, got %0d", stages);
    end

    // --------------------------------------------------
    // Arithmetic
    // --------------------------------------------------
    fp_mult_core u_core (
        .clk (clk),
        .a   (a),
        .b   (b),
        .z   (z_core)
    );

    // --------------------------------------------------
    // Retiming chain
    // --------------------------------------------------
    // Every cycle shifts, valid or not
    // so junk operands ride along with the valid flag low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < stages; i++) begin
                pipe_z[i]     <= '0;
                pipe_valid[i] <= 1'b0;
            end
        end else begin
            pipe_z[0]     <= z_core;
            pipe_valid[0] <= ab_valid;
            for (int i = 1; i < stages; i++) begin
                pipe_z[i]     <= pipe_z[i-1];
                pipe_valid[i] <= pipe_valid[i-1];
            end
        end
    end

    // Last stage drives the product stream
    assign z       = pipe_z[stages-1];
    assign z_valid = pipe_valid[stages-1];

endmodule

// File: src/fp_mult_top.sv
module fp_mult_top (
    input  logic             clk,
    input  logic             rst_n,
    // Operand stream, no back-pressure
    input  fp_pkg::fp_word_t a,
    input  fp_pkg::fp_word_t b,
    input  logic             ab_valid,
    // Product stream, fixed latency behind the operands
    output fp_pkg::fp_word_t z,
    output logic             z_valid
);

    // --------------------------------------------------
    // Pipelined multiplier, default depth
    // --------------------------------------------------
    fp_mult_pipe u_pipe (
        .clk      (clk),
        .rst_n    (rst_n),
        .a        (a),
        .b        (b),
        .ab_valid (ab_valid),
        .z        (z),
        .z_valid  (z_valid)
    );

endmodule

// File: src/fp_pkg.sv
`include "fp_settings.svh"

package fp_pkg;

    // --------------------------------------------------
    // Datapath vector types
    // --------------------------------------------------

    // Packed float
    // Sign on top, then biased exponent, then fraction
    typedef logic [`FP_EXP_WIDTH+`FP_SIG_WIDTH:0] fp_word_t;

    // Biased exponent, two bits wider than the field
    // Signed so sums past the top and below one stay visible
    typedef logic signed [`FP_EXP_WIDTH+1:0] fp_exp_t;

    // Significand with the hidden bit in front
    typedef logic [`FP_SIG_WIDTH:0] fp_sig_t;

    // Full product of two significands
    // Integer part in the top two bits
    typedef logic [2*`FP_SIG_WIDTH+1:0] fp_prod_t;

endpackage

// File: tests/fp_mult_input.txt
# Columns: idle cycles before the pair, operand a, operand b, expected z (all hex)
# Denormals flush to zero, NaN results are 7fc00000
0 3f800000 3f800000 3f800000
0 40000000 40400000 40c00000
0 3fc00000 3fc00000 40100000
2 c0200000 40800000 c1200000
1 3f800800 3f800800 3f801000
0 3fc00000 3f800001 3fc00002
0 3fc00001 3fc00000 40100001
3 3ffffffe 3f800001 40000000
0 7f7fffff 3f800000 7f7fffff
0 7f000000 40000000 7f800000
1 ff000000 7f000000 ff800000
0 00800000 3f000000 00000000
0 80800000 3f000000 80000000
2 00400000 7f000000 00000000
0 80000001 3f800000 80000000
0 7fc00000 3f800000 7fc00000
1 ffa00001 40000000 7fc00000
0 7f800000 00000000 7fc00000
0 7f800000 00000001 7fc00000
2 7f800000 c0000000 ff800000
5 80000000 40400000 80000000

// File: tests/fp_mult_tb.sv
`include "fp_settings.svh"

module fp_mult_tb;

    localparam int MAX_VECTORS    = 64;
    localparam int TIMEOUT_MARGIN = 20;
    localparam int STAGES         = `FP_MULT_STAGES;

    logic             clk;
    logic             rst_n;
    fp_pkg::fp_word_t a;
    fp_pkg::fp_word_t b;
    logic             ab_valid;
    fp_pkg::fp_word_t z;
    logic             z_valid;

    // Vector table, one entry per data line
    int               vec_gap [MAX_VECTORS];
    fp_pkg::fp_word_t vec_a   [MAX_VECTORS];
    fp_pkg::fp_word_t vec_b   [MAX_VECTORS];
    fp_pkg::fp_word_t vec_z   [MAX_VECTORS];
    int               vec_count;

    // Products in flight, oldest at the front
    fp_pkg::fp_word_t exp_q   [$];
    int               issue_q [$];
    fp_pkg::fp_word_t want_z;
    int               want_cycle;

    int               cycle;
    int               cycle_limit;
    int               value_errors;
    int               latency_errors;
    int               stream_errors;
    integer           seed;

    fp_mult_top dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .a        (a),
        .b        (b),
        .ab_valid (ab_valid),
        .z        (z),
        .z_valid  (z_valid)
    );

    always #4 clk = ~clk;

    // --------------------------------------------------
    // Cycle count and timeout
    // --------------------------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            cycle <= cycle + 1;
            if (cycle >= cycle_limit) begin
                $display("Timeout: products still missing after %0d cycles", cycle);
                $display("TESTS FAILED");
                $finish;
            end
        end
    end

    // --------------------------------------------------
    // Output monitor, sampled mid-cycle
    // --------------------------------------------------
    always @(negedge clk) begin
        // Pipeline must be cleared while reset is held
        if (!rst_n && (z !== '0)) begin
            $display("Error: z = %h during reset, expected %h", z, 32'h0);
            value_errors++;
        end
        if (z_valid) begin
            if (exp_q.size() == 0 || issue_q.size() == 0) begin
                $display("z_valid was high in cycle %0d with no product outstanding", cycle);
                stream_errors++;
            end else begin
                want_z     = exp_q.pop_front();
                want_cycle = issue_q.pop_front();
                if (z !== want_z) begin
                    $display("Error: z = %h, expected %h", z, want_z);
                    value_errors++;
                end
                if (cycle != want_cycle + STAGES) begin
                    $display("Product issued in cycle %0d came out in cycle %0d, not %0d",
                             want_cycle, cycle, want_cycle + STAGES);
                    latency_errors++;
                end
            end
        end
        // Accepted operand, remember when
        if (rst_n && ab_valid) begin
            issue_q.push_back(cycle);
        end
    end

    // Comment and blank lines do not scan as four fields and drop out
    task automatic load_vectors();
        int               fd;
        int               n;
        int               gap;
        fp_pkg::fp_word_t va;
        fp_pkg::fp_word_t vb;
        fp_pkg::fp_word_t vz;
        logic [8*256-1:0] line;
        vec_count = 0;
        fd = $fopen("tests/fp_mult_input.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && vec_count < MAX_VECTORS) begin
                line = '0;
                n = $fgets(line, fd);
                n = $sscanf(line, "%h %h %h %h", gap, va, vb, vz);
                if (n == 4) begin
                    vec_gap[vec_count] = gap;
                    vec_a[vec_count]   = va;
                    vec_b[vec_count]   = vb;
                    vec_z[vec_count]   = vz;
                    vec_count++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Idle cycles carry random operands with ab_valid low
    task automatic drive_vectors();
        for (int i = 0; i < vec_count; i++) begin
            for (int g = 0; g < vec_gap[i]; g++) begin
                @(posedge clk);
                a        <= $random(seed);
                b        <= $random(seed);
                ab_valid <= 1'b0;
            end
            @(posedge clk);
            a        <= vec_a[i];
            b        <= vec_b[i];
            ab_valid <= 1'b1;
            exp_q.push_back(vec_z[i]);
        end
        @(posedge clk);
        ab_valid <= 1'b0;
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        a              = '0;
        b              = '0;
        ab_valid       = 1'b0;
        cycle          = 0;
        cycle_limit    = 0;
        value_errors   = 0;
        latency_errors = 0;
        stream_errors  = 0;
        seed           = 32'hb96e8288;
        load_vectors();
        if (vec_count == 0) begin
            $display("No vectors could be read from tests/fp_mult_input.txt");
            $display("TESTS FAILED");
            $finish;
        end else begin
            // Whole stream length plus pipeline depth and some slack
            cycle_limit = vec_count + STAGES + TIMEOUT_MARGIN;
            for (int i = 0; i < vec_count; i++) begin
                cycle_limit += vec_gap[i];
            end
            // Live-looking operands while reset is held, none may come out
            repeat (5) begin
                @(posedge clk);
                a        <= $random(seed);
                b        <= $random(seed);
                ab_valid <= 1'b1;
            end
            rst_n    <= 1'b1;
            ab_valid <= 1'b0;
            drive_vectors();
            while (exp_q.size() != 0) begin
                @(negedge clk);
            end
            // A few idle cycles to catch stray valids
            repeat (STAGES) @(negedge clk);
            $display("Errors: %0d value, %0d latency, %0d stream",
                     value_errors, latency_errors, stream_errors);
            if (value_errors + latency_errors + stream_errors == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

endmodule
